//--- design/rsa_pkg.sv
package rsa_pkg;

    // ----------------------------------------------------------------------
    // bus types
    // ----------------------------------------------------------------------
    typedef logic [31:0] word_t;     // one bus data word
    typedef logic [7:0]  reg_idx_t;  // byte address bits 9..2

    // ----------------------------------------------------------------------
    // register map
    // ----------------------------------------------------------------------
    localparam reg_idx_t REG_CTRL   = 8'd0;  // bit 0 run
    localparam reg_idx_t REG_MODE   = 8'd1;  // bit 0 set = decrypt
    localparam reg_idx_t REG_P      = 8'd2;
    localparam reg_idx_t REG_Q      = 8'd3;
    localparam reg_idx_t REG_MSG    = 8'd4;
    localparam reg_idx_t REG_RESULT = 8'd5;  // read only
    localparam reg_idx_t REG_STATUS = 8'd6;  // read only, bit 0 done

    // fixed public exponent
    localparam int PUBLIC_EXP = 17;

    // ----------------------------------------------------------------------
    // state machines
    // ----------------------------------------------------------------------
    typedef enum logic [1:0] {
        KEY_MULT_N,
        KEY_MULT_PHI,
        KEY_SEARCH,
        KEY_DONE
    } key_state_t;

    typedef enum logic [1:0] {
        EXP_IDLE,
        EXP_STEP,
        EXP_WAIT,
        EXP_DONE
    } exp_state_t;

endpackage

//--- design/rsa_ctrl_if.sv
`timescale 1ns/1ps

interface rsa_ctrl_if #(
    parameter int PRIME_WIDTH = 8
) ();

    typedef logic [PRIME_WIDTH-1:0]   prime_t;
    typedef logic [2*PRIME_WIDTH-1:0] mod_t;

    prime_t p;
    prime_t q;
    mod_t   msg;
    logic   decrypt;
    logic   run;      // level, core cleared while low
    mod_t   result;
    logic   done;     // level, holds until run falls

    modport regs (output p, q, msg, decrypt, run, input result, done);

    modport core (input p, q, msg, decrypt, run, output result, done);

endinterface

//--- design/rsa_reg_bank.sv
`timescale 1ns/1ps

module rsa_reg_bank
    import rsa_pkg::*;
#(
    parameter int PRIME_WIDTH = 8
)(
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        bus_en_i,
    input  logic        bus_we_i,
    input  logic [31:0] bus_addr_i,
    input  word_t       bus_wdata_i,
    output word_t       bus_rdata_o,
    input  logic        lock_i,
    rsa_ctrl_if.regs    ctrl
);

    reg_idx_t idx;
    logic     wr_en;

    assign idx   = reg_idx_t'(bus_addr_i[9:2]);
    assign wr_en = bus_en_i && bus_we_i && !lock_i;  // lock blocks every write

    // ----------------------------------------------------------------------
    // write side
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            ctrl.run     <= 1'b0;
            ctrl.decrypt <= 1'b0;
            ctrl.p       <= '0;
            ctrl.q       <= '0;
            ctrl.msg     <= '0;
        end
        else if (wr_en)
        begin
            case (idx)
                REG_CTRL:
                    ctrl.run <= bus_wdata_i[0];
                REG_MODE:
                    ctrl.decrypt <= bus_wdata_i[0];
                REG_P:
                    ctrl.p <= bus_wdata_i[PRIME_WIDTH-1:0];
                REG_Q:
                    ctrl.q <= bus_wdata_i[PRIME_WIDTH-1:0];
                REG_MSG:
                    ctrl.msg <= bus_wdata_i[2*PRIME_WIDTH-1:0];
                default:
                    ;  // result and status are read only
            endcase
        end
    end

    // ----------------------------------------------------------------------
    // read side, combinational
    // ----------------------------------------------------------------------
    always_comb
    begin
        bus_rdata_o = '0;
        if (bus_en_i && !lock_i)
        begin
            case (idx)
                REG_CTRL:
                    bus_rdata_o = word_t'(ctrl.run);
                REG_MODE:
                    bus_rdata_o = word_t'(ctrl.decrypt);
                REG_P:
                    bus_rdata_o = word_t'(ctrl.p);
                REG_Q:
                    bus_rdata_o = word_t'(ctrl.q);
                REG_MSG:
                    bus_rdata_o = word_t'(ctrl.msg);
                REG_RESULT:
                    bus_rdata_o = word_t'(ctrl.result);
                REG_STATUS:
                    bus_rdata_o = word_t'(ctrl.done);
                default:
                    bus_rdata_o = '0;
            endcase
        end
    end

endmodule

//--- design/rsa_key_gen.sv
`timescale 1ns/1ps

module rsa_key_gen
    import rsa_pkg::*;
#(
    parameter int PRIME_WIDTH = 8
)(
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    rsa_ctrl_if.core                 ctrl,
    output logic [2*PRIME_WIDTH-1:0] modulus_o,
    output logic [2*PRIME_WIDTH-1:0] exponent_o,
    output logic                     key_valid_o
);

    typedef logic [PRIME_WIDTH-1:0]   prime_t;
    typedef logic [2*PRIME_WIDTH-1:0] mod_t;
    typedef logic [2*PRIME_WIDTH:0]   sum_t;   // spare bit for the modular add

    localparam int IDX_W = $clog2(PRIME_WIDTH);

    key_state_t       state_q;
    logic [IDX_W-1:0] bit_idx_q;
    mod_t             acc_q;
    mod_t             phi_q;
    mod_t             cand_q;
    mod_t             sum_q;      // PUBLIC_EXP * cand_q mod phi
    mod_t             modulus_q;
    mod_t             exponent_q;
    prime_t           mul_a;
    prime_t           mul_b;
    mod_t             mul_next;
    sum_t             sum_add;
    sum_t             sum_red;

    // shift-add step, n = p*q first, then phi = (p-1)(q-1)
    always_comb
    begin
        mul_a    = (state_q == KEY_MULT_N) ? ctrl.p : prime_t'(ctrl.p - 1'b1);
        mul_b    = (state_q == KEY_MULT_N) ? ctrl.q : prime_t'(ctrl.q - 1'b1);
        mul_next = (acc_q << 1) + (mul_b[bit_idx_q] ? mod_t'(mul_a) : '0);
        sum_add  = sum_t'(sum_q) + sum_t'(PUBLIC_EXP);
        sum_red  = (sum_add >= sum_t'(phi_q)) ? sum_add - sum_t'(phi_q) : sum_add;
    end

    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            state_q    <= KEY_MULT_N;
            bit_idx_q  <= IDX_W'(PRIME_WIDTH - 1);
            acc_q      <= '0;
            phi_q      <= '0;
            cand_q     <= '0;
            sum_q      <= '0;
            modulus_q  <= '0;
            exponent_q <= '0;
        end
        else if (!ctrl.run)
        begin
            state_q   <= KEY_MULT_N;
            bit_idx_q <= IDX_W'(PRIME_WIDTH - 1);
            acc_q     <= '0;
        end
        else
        begin
            case (state_q)
                KEY_MULT_N, KEY_MULT_PHI:
                begin
                    acc_q     <= mul_next;
                    bit_idx_q <= bit_idx_q - 1'b1;
                    if (bit_idx_q == '0)
                    begin
                        acc_q     <= '0;
                        bit_idx_q <= IDX_W'(PRIME_WIDTH - 1);
                        if (state_q == KEY_MULT_N)
                        begin
                            modulus_q <= mul_next;
                            state_q   <= KEY_MULT_PHI;
                        end
                        else
                        begin
                            phi_q      <= mul_next;
                            cand_q     <= mod_t'(1);
                            sum_q      <= mod_t'(PUBLIC_EXP);
                            exponent_q <= mod_t'(PUBLIC_EXP);
                            state_q    <= ctrl.decrypt ? KEY_SEARCH : KEY_DONE;
                        end
                    end
                end
                KEY_SEARCH:
                begin
                    // cand_q >= phi_q means no inverse exists, give up
                    if (sum_q == mod_t'(1) || cand_q >= phi_q)
                    begin
                        exponent_q <= cand_q;
                        state_q    <= KEY_DONE;
                    end
                    else if (sum_q >= phi_q)
                        sum_q <= sum_q - phi_q;    // only for totients below 17
                    else
                    begin
                        cand_q <= cand_q + 1'b1;
                        sum_q  <= mod_t'(sum_red);
                    end
                end
                default:
                    ;  // hold key until run falls
            endcase
        end
    end

    assign modulus_o   = modulus_q;
    assign exponent_o  = exponent_q;
    assign key_valid_o = (state_q == KEY_DONE);

endmodule

//--- design/rsa_mod_mult.sv
`timescale 1ns/1ps

module rsa_mod_mult
    import rsa_pkg::*;
#(
    parameter int PRIME_WIDTH = 8
)(
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     start_i,
    input  logic [2*PRIME_WIDTH-1:0] a_i,
    input  logic [2*PRIME_WIDTH-1:0] b_i,
    input  logic [2*PRIME_WIDTH-1:0] m_i,
    output logic [2*PRIME_WIDTH-1:0] product_o,
    output logic                     done_o
);

    typedef logic [2*PRIME_WIDTH-1:0] mod_t;
    typedef logic [2*PRIME_WIDTH+1:0] wide_t;  // holds 2*acc + a < 3m

    localparam int CNT_W = $clog2(2*PRIME_WIDTH + 1);

    logic [CNT_W-1:0] cnt_q;     // bits left to process
    logic             done_q;
    mod_t             a_q;
    mod_t             b_q;
    mod_t             m_q;
    mod_t             acc_q;
    wide_t            dbl;
    wide_t            red1;
    wide_t            red2;

    // double, add, reduce twice
    always_comb
    begin
        dbl  = (wide_t'(acc_q) << 1) + (b_q[2*PRIME_WIDTH-1] ? wide_t'(a_q) : '0);
        red1 = (dbl >= wide_t'(m_q)) ? dbl - wide_t'(m_q) : dbl;
        red2 = (red1 >= wide_t'(m_q)) ? red1 - wide_t'(m_q) : red1;
    end

    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            cnt_q  <= '0;
            done_q <= 1'b0;
        end
        else
        begin
            done_q <= (cnt_q == CNT_W'(1)) && !start_i;
            if (start_i)
                cnt_q <= CNT_W'(2*PRIME_WIDTH);
            else if (cnt_q != '0)
                cnt_q <= cnt_q - 1'b1;
        end
    end

    // operands and accumulator
    always_ff @(posedge clk_i)
    begin
        if (start_i)
        begin
            a_q   <= a_i;
            b_q   <= b_i;
            m_q   <= m_i;
            acc_q <= '0;
        end
        else if (cnt_q != '0)
        begin
            acc_q <= mod_t'(red2);
            b_q   <= b_q << 1;   // msb first
        end
    end

    assign product_o = acc_q;
    assign done_o    = done_q;

endmodule

//--- design/rsa_mod_exp.sv
`timescale 1ns/1ps

module rsa_mod_exp
    import rsa_pkg::*;
#(
    parameter int PRIME_WIDTH = 8
)(
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    rsa_ctrl_if.core                 ctrl,
    input  logic [2*PRIME_WIDTH-1:0] modulus_i,
    input  logic [2*PRIME_WIDTH-1:0] exponent_i,
    input  logic                     key_valid_i
);

    typedef logic [2*PRIME_WIDTH-1:0] mod_t;

    exp_state_t state_q;
    mod_t       base_q;
    mod_t       acc_q;
    mod_t       exp_q;       // exponent bits still to consume
    mod_t       sq_product;
    mod_t       pr_product;
    logic       sq_done;
    logic       pr_done;
    logic       mult_start;

    assign mult_start = (state_q == EXP_STEP) && (exp_q != '0);

    // ----------------------------------------------------------------------
    // base squaring and accumulator product side by side
    // ----------------------------------------------------------------------
    rsa_mod_mult #(
        .PRIME_WIDTH (PRIME_WIDTH)
    ) u_square (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .start_i   (mult_start),
        .a_i       (base_q),
        .b_i       (base_q),
        .m_i       (modulus_i),
        .product_o (sq_product),
        .done_o    (sq_done)
    );

    rsa_mod_mult #(
        .PRIME_WIDTH (PRIME_WIDTH)
    ) u_product (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .start_i   (mult_start),
        .a_i       (acc_q),
        .b_i       (base_q),
        .m_i       (modulus_i),
        .product_o (pr_product),
        .done_o    (pr_done)
    );

    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            state_q     <= EXP_IDLE;
            base_q      <= '0;
            acc_q       <= '0;
            exp_q       <= '0;
            ctrl.result <= '0;
        end
        else if (!ctrl.run)
            state_q <= EXP_IDLE;
        else
        begin
            case (state_q)
                EXP_IDLE:
                    if (key_valid_i)
                    begin
                        base_q  <= ctrl.msg;
                        acc_q   <= mod_t'(1);
                        exp_q   <= exponent_i;
                        state_q <= EXP_STEP;
                    end
                EXP_STEP:
                    if (exp_q == '0)
                    begin
                        ctrl.result <= acc_q;   // last set bit consumed
                        state_q     <= EXP_DONE;
                    end
                    else
                        state_q <= EXP_WAIT;
                EXP_WAIT:
                    if (sq_done && pr_done)
                    begin
                        base_q <= sq_product;
                        if (exp_q[0])
                            acc_q <= pr_product;
                        exp_q   <= exp_q >> 1;
                        state_q <= EXP_STEP;
                    end
                default:
                    ;  // EXP_DONE holds until run falls
            endcase
        end
    end

    assign ctrl.done = (state_q == EXP_DONE);

endmodule

//--- design/rsa_accel_top.sv
`timescale 1ns/1ps

module rsa_accel_top
    import rsa_pkg::*;
#(
    parameter int PRIME_WIDTH = 8   // 2*PRIME_WIDTH fits one bus word
)(
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        bus_en_i,
    input  logic        bus_we_i,
    input  logic [31:0] bus_addr_i,
    input  word_t       bus_wdata_i,
    output word_t       bus_rdata_o,
    input  logic        lock_i
);

    typedef logic [2*PRIME_WIDTH-1:0] mod_t;

    mod_t modulus;
    mod_t exponent;
    logic key_valid;

    rsa_ctrl_if #(
        .PRIME_WIDTH (PRIME_WIDTH)
    ) u_ctrl ();

    rsa_reg_bank #(
        .PRIME_WIDTH (PRIME_WIDTH)
    ) u_reg_bank (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .bus_en_i    (bus_en_i),
        .bus_we_i    (bus_we_i),
        .bus_addr_i  (bus_addr_i),
        .bus_wdata_i (bus_wdata_i),
        .bus_rdata_o (bus_rdata_o),
        .lock_i      (lock_i),
        .ctrl        (u_ctrl)
    );

    // key derivation feeds the exponentiator
    rsa_key_gen #(
        .PRIME_WIDTH (PRIME_WIDTH)
    ) u_key_gen (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .ctrl        (u_ctrl),
        .modulus_o   (modulus),
        .exponent_o  (exponent),
        .key_valid_o (key_valid)
    );

    rsa_mod_exp #(
        .PRIME_WIDTH (PRIME_WIDTH)
    ) u_mod_exp (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .ctrl        (u_ctrl),
        .modulus_i   (modulus),
        .exponent_i  (exponent),
        .key_valid_i (key_valid)
    );

endmodule

//--- tb/rsa_accel_assertions.sv
`timescale 1ns/1ps

module rsa_accel_assertions
    import rsa_pkg::*;
(
    input logic  clk_i,
    input logic  rst_n_i,
    input logic  lock_i,
    input logic  run_i,
    input logic  done_i,
    input word_t rdata_i
);

    // ----------------------------------------------------------------------
    // control levels
    // ----------------------------------------------------------------------
    // done drops one edge after run, so allow that cycle
    property done_needs_run;
        @(posedge clk_i) disable iff (!rst_n_i)
            done_i |-> (run_i || $past(run_i));
    endproperty

    property done_holds;
        @(posedge clk_i) disable iff (!rst_n_i)
            (done_i && run_i) |=> done_i;
    endproperty

    // ----------------------------------------------------------------------
    // lock
    // ----------------------------------------------------------------------
    property lock_zero_read;
        @(posedge clk_i) disable iff (!rst_n_i)
            lock_i |-> (rdata_i == '0);
    endproperty

    assert property (done_needs_run) else $error("done high while run is low");
    assert property (done_holds) else $error("done fell while run stayed high");
    assert property (lock_zero_read) else $error("read data not zero under lock");

endmodule

bind rsa_accel_top rsa_accel_assertions u_assertions (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .lock_i  (lock_i),
    .run_i   (u_ctrl.run),
    .done_i  (u_ctrl.done),
    .rdata_i (bus_rdata_o)
);

//--- tb/rsa_tb.sv
`timescale 1ns/1ps

module rsa_tb
    import rsa_pkg::*;
();

    localparam int PW         = 8;
    localparam int NUM_RANDOM = 4;
    localparam int NUM_RUNS   = 3 + 2*NUM_RANDOM;           // fixed pair, lock, random pairs
    localparam int RUN_CYCLES = 2*PW + 65536 + 16*17;
    localparam int MAX_CYCLES = NUM_RUNS*RUN_CYCLES + 5000;

    logic        clk_i;
    logic        rst_n_i;
    logic        bus_en_i;
    logic        bus_we_i;
    logic [31:0] bus_addr_i;
    word_t       bus_wdata_i;
    word_t       bus_rdata_o;
    logic        lock_i;

    int          pass_cnt;
    int          fail_cnt;
    int          cycle_cnt;
    logic [15:0] lfsr_q;
    int unsigned primes[$];

    rsa_accel_top #(
        .PRIME_WIDTH (PW)
    ) dut (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .bus_en_i    (bus_en_i),
        .bus_we_i    (bus_we_i),
        .bus_addr_i  (bus_addr_i),
        .bus_wdata_i (bus_wdata_i),
        .bus_rdata_o (bus_rdata_o),
        .lock_i      (lock_i)
    );

    always #10 clk_i = ~clk_i;

    // ----------------------------------------------------------------------
    // random numbers
    // ----------------------------------------------------------------------
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic rand_bits(input int n, output int unsigned val);
        val = 0;
        for (int i = 0; i < n; i++)
        begin
            val    = (val << 1) | lfsr_q[0];
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    function automatic bit is_prime(input int v);
        if (v < 2)
            return 1'b0;
        for (int k = 2; k*k <= v; k++)
            if (v % k == 0)
                return 1'b0;
        return 1'b1;
    endfunction

    // ----------------------------------------------------------------------
    // reference model
    // ----------------------------------------------------------------------
    function automatic longint unsigned ref_mod_exp(input longint unsigned base,
                                                    input longint unsigned e,
                                                    input longint unsigned m);
        longint unsigned acc;
        longint unsigned b;
        longint unsigned k;
        acc = 1;
        b   = base % m;
        k   = e;
        while (k != 0)
        begin
            if (k[0])
                acc = (acc * b) % m;
            b = (b * b) % m;
            k = k >> 1;
        end
        return acc;
    endfunction

    // smallest d with 17*d = 1 mod phi, phi itself when there is none
    function automatic longint unsigned ref_priv_exp(input longint unsigned phi);
        for (longint unsigned d = 1; d < phi; d++)
            if ((PUBLIC_EXP * d) % phi == 1)
                return d;
        return phi;
    endfunction

    // ----------------------------------------------------------------------
    // compare tasks
    // ----------------------------------------------------------------------
    task automatic check_word(input string what, input word_t exp, input word_t act);
        if (act === exp)
        begin
            pass_cnt++;
            $display("ok   %s = 0x%0h", what, act);
        end
        else
        begin
            fail_cnt++;
            $display("FAIL t=%0t %s expected 0x%0h got 0x%0h", $time, what, exp, act);
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (act === exp)
        begin
            pass_cnt++;
            $display("ok   %s = %b", what, act);
        end
        else
        begin
            fail_cnt++;
            $display("FAIL t=%0t %s expected %b got %b", $time, what, exp, act);
        end
    endtask

    // ----------------------------------------------------------------------
    // bus tasks, entered and left on a falling edge
    // ----------------------------------------------------------------------
    task automatic bus_write(input reg_idx_t idx, input word_t data);
        bus_en_i    = 1'b1;
        bus_we_i    = 1'b1;
        bus_addr_i  = {22'd0, idx, 2'b00};
        bus_wdata_i = data;
        @(negedge clk_i);
        bus_en_i = 1'b0;
        bus_we_i = 1'b0;
    endtask

    task automatic bus_read(input reg_idx_t idx, output word_t data);
        bus_en_i   = 1'b1;
        bus_we_i   = 1'b0;
        bus_addr_i = {22'd0, idx, 2'b00};
        @(negedge clk_i);
        data     = bus_rdata_o;   // settled since the rising edge
        bus_en_i = 1'b0;
    endtask

    task automatic poll_done();
        word_t s;
        s = '0;
        while (s[0] !== 1'b1)
            bus_read(REG_STATUS, s);
    endtask

    task automatic run_core(input logic decrypt, input int unsigned p, input int unsigned q,
                            input int unsigned msg, output word_t result);
        bus_write(REG_P, p);
        bus_write(REG_Q, q);
        bus_write(REG_MSG, msg);
        bus_write(REG_MODE, word_t'(decrypt));
        bus_write(REG_CTRL, 1);
        poll_done();
        bus_read(REG_RESULT, result);
    endtask

    task automatic stop_core(input string tag);
        word_t s;
        bus_write(REG_CTRL, 0);
        bus_read(REG_STATUS, s);
        check_flag({tag, " status after run cleared"}, 1'b0, s[0]);
    endtask

    // ----------------------------------------------------------------------
    // tests
    // ----------------------------------------------------------------------
    task automatic round_trip(input int unsigned p, input int unsigned q,
                              input int unsigned msg, input string tag);
        longint unsigned n;
        longint unsigned d;
        longint unsigned c_exp;
        longint unsigned m_exp;
        word_t           rd;
        n     = p * q;
        d     = ref_priv_exp((p - 1) * (q - 1));
        c_exp = ref_mod_exp(msg, PUBLIC_EXP, n);
        m_exp = ref_mod_exp(c_exp, d, n);
        run_core(1'b0, p, q, msg, rd);
        check_word({tag, " encrypt"}, word_t'(c_exp), rd);
        stop_core(tag);
        run_core(1'b1, p, q, c_exp, rd);
        check_word({tag, " decrypt"}, word_t'(m_exp), rd);
        check_word({tag, " round trip"}, word_t'(msg), rd);
        stop_core(tag);
    endtask

    task automatic lock_test();
        longint unsigned c_exp;
        word_t           rd;
        c_exp = ref_mod_exp(100, PUBLIC_EXP, 11 * 13);
        bus_write(REG_P, 11);
        bus_write(REG_Q, 13);
        bus_write(REG_MSG, 100);
        bus_write(REG_MODE, 0);
        lock_i = 1'b1;
        bus_write(REG_P, 17);       // all of these must be dropped
        bus_write(REG_Q, 19);
        bus_write(REG_MSG, 5);
        bus_write(REG_CTRL, 1);
        lock_i = 1'b0;
        bus_read(REG_P, rd);
        check_word("p kept under lock", 11, rd);
        bus_read(REG_CTRL, rd);
        check_word("run blocked under lock", '0, rd);
        bus_write(REG_CTRL, 1);
        poll_done();
        lock_i = 1'b1;
        bus_read(REG_STATUS, rd);
        check_word("locked status when done", '0, rd);
        bus_read(REG_RESULT, rd);
        check_word("locked result when done", '0, rd);
        lock_i = 1'b0;
        bus_read(REG_RESULT, rd);
        check_word("lock encrypt", word_t'(c_exp), rd);
        stop_core("lock");
    endtask

    initial
    begin
        int unsigned pi;
        int unsigned qi;
        int unsigned r;
        longint unsigned n;
        word_t rd;
        clk_i       = 1'b0;
        rst_n_i     = 1'b0;
        bus_en_i    = 1'b0;
        bus_we_i    = 1'b0;
        bus_addr_i  = '0;
        bus_wdata_i = '0;
        lock_i      = 1'b0;
        lfsr_q      = 16'd56394;
        pass_cnt    = 0;
        fail_cnt    = 0;
        for (int v = 2; v < 256; v++)
            if (is_prime(v) && ((v - 1) % PUBLIC_EXP != 0))
                primes.push_back(v);
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;
        @(negedge clk_i);

        bus_read(REG_STATUS, rd);
        check_word("reset status", '0, rd);
        bus_read(REG_RESULT, rd);
        check_word("reset result", '0, rd);

        round_trip(61, 53, 65, "fixed");
        lock_test();

        for (int i = 0; i < NUM_RANDOM; i++)
        begin
            rand_bits(6, r);
            pi = primes[r % primes.size()];
            qi = pi;
            while (qi == pi)
            begin
                rand_bits(6, r);
                qi = primes[r % primes.size()];
            end
            n = pi * qi;
            rand_bits(16, r);
            round_trip(pi, qi, r % n, $sformatf("random %0d (p=%0d q=%0d)", i, pi, qi));
        end

        $display("checks passed %0d failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

    // watchdog
    initial
    begin
        cycle_cnt = 0;
        while (cycle_cnt < MAX_CYCLES)
        begin
            @(posedge clk_i);
            cycle_cnt++;
        end
        $display("timeout: the core did not finish within %0d cycles", cycle_cnt);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

//--- list.f
design/rsa_pkg.sv
design/rsa_ctrl_if.sv
design/rsa_reg_bank.sv
design/rsa_key_gen.sv
design/rsa_mod_mult.sv
design/rsa_mod_exp.sv
design/rsa_accel_top.sv
tb/rsa_accel_assertions.sv
tb/rsa_tb.sv

//--- Bender.yml
package:
  name: rsa_accel

sources:
  - design/rsa_pkg.sv
  - design/rsa_ctrl_if.sv
  - design/rsa_reg_bank.sv
  - design/rsa_key_gen.sv
  - design/rsa_mod_mult.sv
  - design/rsa_mod_exp.sv
  - design/rsa_accel_top.sv
  - target: test
    files:
      - tb/rsa_accel_assertions.sv
      - tb/rsa_tb.sv
